// File: logic/cpu_types_pkg.sv
package cpu_types_pkg;

  // one data word as seen by the caches and the RAM
  typedef logic [31:0] word_t;

  // byte address, always word aligned on this bus
  typedef logic [31:0] addr_t;

  // RAM status, reported every cycle
  // FREE when idle, BUSY while counting down,
  // ACCESS for the single cycle the data moves
  // ERROR on a bad request
  typedef enum logic [1:0] {
    FREE,
    BUSY,
    ACCESS,
    ERROR
  } ramstate_t;

  // two cores only, the protocol always names a single peer
  localparam int CPUS = 2;

  // busy cycles ahead of every ACCESS cycle
  localparam int RAM_LAT = 2;

  // RAM size in words
  localparam int RAM_DEPTH = 256;

endpackage

// File: logic/coherence_pkg.sv
package coherence_pkg;

  // controller states
  typedef enum logic [3:0] {
    // waiting for a granted request
    IDLE,
    // snoop cycles, peer gets ccwait and the snoop address
    PRRD,
    PRWR,
    // read of a clean line from RAM, two words
    BUSRD1,
    BUSRD2,
    // read served by the peer, copied into RAM too
    BUSWB1,
    BUSWB2,
    // write miss from RAM, peer invalidated
    BUSRDX1,
    BUSRDX2,
    // write miss served by the peer, RAM untouched
    BUSWBX1,
    BUSWBX2,
    // instruction fetch
    IMEM,
    // dcache flush of one word to RAM
    CACWB
  } memory_control_t;

  // index of the core holding the grant
  typedef logic arb_t;

endpackage

// File: logic/ram_model.sv
module ram_model
  import cpu_types_pkg::*;
(
  input  logic      CLK,
  input  logic      nRST,
  input  logic      ramren,
  input  logic      ramwen,
  input  addr_t     ramaddr,
  input  word_t     ramstore,
  output word_t     ramload,
  output ramstate_t ramstate
);

  word_t                          mem [RAM_DEPTH];
  logic [$clog2(RAM_DEPTH)-1:0]   word_idx;
  logic [$clog2(RAM_LAT+1)-1:0]   lat_cnt;
  logic                           ram_req;
  logic                           bad_req;

  // byte address to word index
  assign word_idx = ramaddr[$clog2(RAM_DEPTH)+1:2];

  assign ram_req = ramren | ramwen;

  // both directions at once, misaligned or past the end
  assign bad_req = (ramren & ramwen)
                 | (ramaddr[1:0] != 2'b00)
                 | (ramaddr >= addr_t'(RAM_DEPTH * 4));

  always_comb begin
    if (!ram_req) begin
      ramstate = FREE;
    end else if (bad_req) begin
      ramstate = ERROR;
    end else if (lat_cnt == RAM_LAT) begin
      ramstate = ACCESS;
    end else begin
      ramstate = BUSY;
    end
  end

  // counts busy cycles, restarts after each ACCESS
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      lat_cnt <= '0;
    end else if (ramstate == BUSY) begin
      lat_cnt <= lat_cnt + 1'b1;
    end else begin
      lat_cnt <= '0;
    end
  end

  // write lands at the end of the ACCESS cycle
  always_ff @(posedge CLK) begin
    if (ramstate == ACCESS && ramwen) begin
      mem[word_idx] <= ramstore;
    end
  end

  // read data only meaningful in ACCESS
  assign ramload = mem[word_idx];

endmodule

// File: logic/memory_control.sv
module memory_control
  import cpu_types_pkg::*, coherence_pkg::*;
(
  input  logic                 CLK,
  input  logic                 nRST,
  // cache requests
  input  logic      [CPUS-1:0] iren,
  input  logic      [CPUS-1:0] dren,
  input  logic      [CPUS-1:0] dwen,
  input  addr_t     [CPUS-1:0] iaddr,
  input  addr_t     [CPUS-1:0] daddr,
  input  word_t     [CPUS-1:0] dstore,
  // coherence inputs
  input  logic      [CPUS-1:0] ccwrite,
  input  logic      [CPUS-1:0] cctrans,
  // RAM responses
  input  word_t                ramload,
  input  ramstate_t            ramstate,
  // cache responses
  output logic      [CPUS-1:0] iwait,
  output logic      [CPUS-1:0] dwait,
  output word_t     [CPUS-1:0] iload,
  output word_t     [CPUS-1:0] dload,
  // coherence outputs
  output logic      [CPUS-1:0] ccwait,
  output logic      [CPUS-1:0] ccinv,
  output addr_t     [CPUS-1:0] ccsnoopaddr,
  // RAM requests
  output logic                 ramren,
  output logic                 ramwen,
  output addr_t                ramaddr,
  output word_t                ramstore
);

  memory_control_t state;
  memory_control_t next_state;
  arb_t            arb;
  arb_t            next_arb;
  arb_t            peer;
  logic [CPUS-1:0] core_req;
  logic            ram_done;

  // the other core
  assign peer = ~arb;

  // any request at all per core
  assign core_req = iren | dren | dwen;

  // RAM finished the current word
  assign ram_done = (ramstate == ACCESS);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
      arb   <= 1'b0;
    end else begin
      state <= next_state;
      arb   <= next_arb;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        // only the granted core can start a transaction
        if (dren[arb]) begin
          next_state = PRRD;
        end else if (dwen[arb] && ccwrite[arb]) begin
          // dwen with ccwrite marks a write miss
          next_state = PRWR;
        end else if (dwen[arb]) begin
          // plain dwen is a flush
          next_state = CACWB;
        end else if (iren[arb]) begin
          next_state = IMEM;
        end
      end
      // snoop result picks the data source
      PRRD: next_state = ccwrite[peer] ? BUSWB1 : BUSRD1;
      PRWR: next_state = ccwrite[peer] ? BUSWBX1 : BUSRDX1;
      // RAM-backed words advance on ACCESS
      BUSRD1:  next_state = ram_done ? BUSRD2 : state;
      BUSRD2:  next_state = ram_done ? IDLE : state;
      BUSWB1:  next_state = ram_done ? BUSWB2 : state;
      BUSWB2:  next_state = ram_done ? IDLE : state;
      BUSRDX1: next_state = ram_done ? BUSRDX2 : state;
      BUSRDX2: next_state = ram_done ? IDLE : state;
      // peer to requester takes one cycle per word
      BUSWBX1: next_state = BUSWBX2;
      BUSWBX2: next_state = IDLE;
      IMEM:    next_state = ram_done ? IDLE : state;
      CACWB:   next_state = ram_done ? IDLE : state;
      default: next_state = IDLE;
    endcase
    // a cache in transition freezes everything
    if (cctrans != '0) begin
      next_state = state;
    end
  end

  // grant moves only between transactions
  always_comb begin
    next_arb = arb;
    if (state == IDLE && next_state == IDLE && cctrans == '0) begin
      // holder keeps it while it asks and hands over otherwise
      if (!core_req[arb] && core_req[peer]) begin
        next_arb = peer;
      end
    end
  end

  always_comb begin
    // everyone waits unless a state says otherwise
    iwait       = '1;
    dwait       = '1;
    iload       = '0;
    dload       = '0;
    ccwait      = '0;
    ccinv       = '0;
    ccsnoopaddr = '0;
    ramren      = 1'b0;
    ramwen      = 1'b0;
    ramaddr     = '0;
    ramstore    = '0;

    if (cctrans[0]) begin
      // core 1 drops its copy while core 0 changes a line
      ccwait[1]      = 1'b1;
      ccinv[1]       = 1'b1;
      ccsnoopaddr[1] = daddr[0];
    end else if (cctrans[1]) begin
      ccwait[0]      = 1'b1;
      ccinv[0]       = 1'b1;
      ccsnoopaddr[0] = daddr[1];
    end else begin
      case (state)
        PRRD, PRWR: begin
          // peer looks up the line this cycle
          ccwait[peer]      = 1'b1;
          ccsnoopaddr[peer] = daddr[arb];
        end
        BUSRD1, BUSRD2: begin
          dwait[arb] = ~ram_done;
          dload[arb] = ramload;
          ramren     = 1'b1;
          ramaddr    = daddr[arb];
        end
        BUSWB1, BUSWB2: begin
          // peer data to requester and into RAM
          dwait[arb] = ~ram_done;
          dload[arb] = dstore[peer];
          ramwen     = 1'b1;
          // requester daddr tracks the word being moved
          ramaddr           = daddr[arb];
          ramstore          = dstore[peer];
          ccwait[peer]      = 1'b1;
          ccsnoopaddr[peer] = daddr[arb];
        end
        BUSRDX1, BUSRDX2: begin
          dwait[arb]        = ~ram_done;
          dload[arb]        = ramload;
          ramren            = 1'b1;
          ramaddr           = daddr[arb];
          ccwait[peer]      = 1'b1;
          ccsnoopaddr[peer] = daddr[arb];
          // invalidate on the last word
          ccinv[peer] = (state == BUSRDX2);
        end
        BUSWBX1, BUSWBX2: begin
          // cache to cache transfer leaves RAM untouched
          dwait[arb]        = 1'b0;
          dload[arb]        = dstore[peer];
          ccwait[peer]      = 1'b1;
          ccsnoopaddr[peer] = daddr[arb];
          ccinv[peer]       = (state == BUSWBX2);
        end
        IMEM: begin
          iwait[arb] = ~ram_done;
          iload[arb] = ramload;
          ramren     = 1'b1;
          ramaddr    = iaddr[arb];
        end
        CACWB: begin
          // dwait low means the word is in RAM
          dwait[arb] = ~ram_done;
          ramwen     = 1'b1;
          ramaddr    = daddr[arb];
          ramstore   = dstore[arb];
        end
        default: begin
          // IDLE drives nothing
        end
      endcase
    end
  end

endmodule

// File: logic/memory_subsystem.sv
module memory_subsystem
  import cpu_types_pkg::*;
(
  input  logic             CLK,
  input  logic             nRST,
  input  logic  [CPUS-1:0] iren,
  input  logic  [CPUS-1:0] dren,
  input  logic  [CPUS-1:0] dwen,
  input  addr_t [CPUS-1:0] iaddr,
  input  addr_t [CPUS-1:0] daddr,
  input  word_t [CPUS-1:0] dstore,
  input  logic  [CPUS-1:0] ccwrite,
  input  logic  [CPUS-1:0] cctrans,
  output logic  [CPUS-1:0] iwait,
  output logic  [CPUS-1:0] dwait,
  output word_t [CPUS-1:0] iload,
  output word_t [CPUS-1:0] dload,
  output logic  [CPUS-1:0] ccwait,
  output logic  [CPUS-1:0] ccinv,
  output addr_t [CPUS-1:0] ccsnoopaddr
);

  // controller to RAM
  logic      ramren;
  logic      ramwen;
  addr_t     ramaddr;
  word_t     ramstore;
  word_t     ramload;
  ramstate_t ramstate;

  memory_control u_ctrl (
    .CLK         (CLK),
    .nRST        (nRST),
    .iren        (iren),
    .dren        (dren),
    .dwen        (dwen),
    .iaddr       (iaddr),
    .daddr       (daddr),
    .dstore      (dstore),
    .ccwrite     (ccwrite),
    .cctrans     (cctrans),
    .ramload     (ramload),
    .ramstate    (ramstate),
    .iwait       (iwait),
    .dwait       (dwait),
    .iload       (iload),
    .dload       (dload),
    .ccwait      (ccwait),
    .ccinv       (ccinv),
    .ccsnoopaddr (ccsnoopaddr),
    .ramren      (ramren),
    .ramwen      (ramwen),
    .ramaddr     (ramaddr),
    .ramstore    (ramstore)
  );

  // single shared RAM, fixed latency
  ram_model u_ram (
    .CLK      (CLK),
    .nRST     (nRST),
    .ramren   (ramren),
    .ramwen   (ramwen),
    .ramaddr  (ramaddr),
    .ramstore (ramstore),
    .ramload  (ramload),
    .ramstate (ramstate)
  );

endmodule

// File: dv/tb_clock.sv
module tb_clock (
  output logic CLK,
  output logic nRST
);

  // 40-unit period, toggles every 20
  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  // reset low for the first two rising edges
  initial begin
    nRST = 1'b0;
    repeat (2) @(posedge CLK);
    #2 nRST = 1'b1;
  end

endmodule

// File: dv/memory_subsystem_tb.sv
module memory_subsystem_tb
  import cpu_types_pkg::*;
();

  localparam logic [31:0] LFSR_SEED = 32'h47d9_b938;
  // about 40 transactions of up to 8 cycles, plus reset, stalls and margin
  localparam int TXN_COUNT  = 40;
  localparam int TXN_CYCLES = 8;
  localparam int MAX_CYCLES = TXN_COUNT * TXN_CYCLES + 280;

  logic             CLK;
  logic             nRST;
  logic  [CPUS-1:0] iren;
  logic  [CPUS-1:0] dren;
  logic  [CPUS-1:0] dwen;
  addr_t [CPUS-1:0] iaddr;
  addr_t [CPUS-1:0] daddr;
  word_t [CPUS-1:0] dstore;
  logic  [CPUS-1:0] ccwrite;
  logic  [CPUS-1:0] cctrans;
  logic  [CPUS-1:0] iwait;
  logic  [CPUS-1:0] dwait;
  word_t [CPUS-1:0] iload;
  word_t [CPUS-1:0] dload;
  logic  [CPUS-1:0] ccwait;
  logic  [CPUS-1:0] ccinv;
  addr_t [CPUS-1:0] ccsnoopaddr;

  // expected RAM contents, kept by the cache models
  word_t            ref_mem [RAM_DEPTH];
  logic [31:0]      lfsr_state;
  int               errors = 0;
  int               cycles = 0;
  // first snoop address and any invalidate, per core
  logic  [CPUS-1:0] snoop_seen;
  addr_t [CPUS-1:0] snoop_addr;
  logic  [CPUS-1:0] inv_seen;

  tb_clock clk_gen (
    .CLK  (CLK),
    .nRST (nRST)
  );

  memory_subsystem memory_subsystem_i (
    .CLK         (CLK),
    .nRST        (nRST),
    .iren        (iren),
    .dren        (dren),
    .dwen        (dwen),
    .iaddr       (iaddr),
    .daddr       (daddr),
    .dstore      (dstore),
    .ccwrite     (ccwrite),
    .cctrans     (cctrans),
    .iwait       (iwait),
    .dwait       (dwait),
    .iload       (iload),
    .dload       (dload),
    .ccwait      (ccwait),
    .ccinv       (ccinv),
    .ccsnoopaddr (ccsnoopaddr)
  );

  task automatic report_mismatch(input string msg);
    errors++;
    $display("CHECK FAILED at time %0t: %s", $time, msg);
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] next_lfsr(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one step per bit
  function automatic word_t rand_word();
    word_t w;
    for (int i = 0; i < 32; i++) begin
      lfsr_state = next_lfsr(lfsr_state);
      w[i] = lfsr_state[0];
    end
    return w;
  endfunction

  function automatic logic [$clog2(RAM_DEPTH)-1:0] word_index(input addr_t addr);
    return addr[$clog2(RAM_DEPTH)+1:2];
  endfunction

  // inputs change just after the rising edge
  task automatic drive_slot();
    @(posedge CLK);
    #2;
  endtask

  // outputs sampled mid-cycle, where they are settled
  task automatic wait_for_ready(input int c, input bit fetch);
    do begin
      @(negedge CLK);
    end while (fetch ? iwait[c] : dwait[c]);
  endtask

  task automatic flush_word(input int c, input addr_t addr, output int done);
    word_t data;
    data       = rand_word();
    dwen[c]    = 1'b1;
    ccwrite[c] = 1'b0;
    daddr[c]   = addr;
    dstore[c]  = data;
    wait_for_ready(c, 1'b0);
    done = cycles;
    drive_slot();
    dwen[c] = 1'b0;
    ref_mem[word_index(addr)] = data;
  endtask

  task automatic fetch_word(input int c, input addr_t addr, output int done);
    word_t expect_word;
    expect_word = ref_mem[word_index(addr)];
    iren[c]  = 1'b1;
    iaddr[c] = addr;
    wait_for_ready(c, 1'b1);
    assert (iload[c] == expect_word)
      else report_mismatch($sformatf("core %0d fetch of %h gave %h, expected %h",
                                     c, addr, iload[c], expect_word));
    done = cycles;
    drive_slot();
    iren[c] = 1'b0;
  endtask

  // two-word read or write miss, peer optionally supplying the line
  task automatic data_block(input int c, input addr_t addr, input bit miss,
                            input bit peer_has);
    int    p;
    word_t peer_word [2];
    word_t expect_word;
    addr_t word_addr;
    p            = 1 - c;
    peer_word[0] = rand_word();
    peer_word[1] = rand_word();
    snoop_seen[p] = 1'b0;
    inv_seen[p]   = 1'b0;
    dren[c]    = !miss;
    dwen[c]    = miss;
    ccwrite[c] = miss;
    daddr[c]   = addr;
    ccwrite[p] = peer_has;
    dstore[p]  = peer_word[0];
    for (int w = 0; w < 2; w++) begin
      word_addr   = addr + addr_t'(4 * w);
      expect_word = peer_has ? peer_word[w] : ref_mem[word_index(word_addr)];
      wait_for_ready(c, 1'b0);
      assert (dload[c] == expect_word)
        else report_mismatch($sformatf("core %0d word %h loaded %h, expected %h",
                                       c, word_addr, dload[c], expect_word));
      // snooped read also lands in RAM, a write miss never does
      if (peer_has && !miss) begin
        ref_mem[word_index(word_addr)] = peer_word[w];
      end
      drive_slot();
      if (w == 0) begin
        daddr[c]  = addr + 32'd4;
        dstore[p] = peer_word[1];
      end
    end
    dren[c]    = 1'b0;
    dwen[c]    = 1'b0;
    ccwrite[c] = 1'b0;
    ccwrite[p] = 1'b0;
    assert (snoop_seen[p] && snoop_addr[p] == addr)
      else report_mismatch($sformatf("peer %0d not snooped with %h", p, addr));
    if (miss) begin
      assert (inv_seen[p])
        else report_mismatch($sformatf("no ccinv to peer %0d on write miss", p));
    end
  endtask

  task automatic hold_trans(input int c, input addr_t addr, input int len,
                            output int done);
    cctrans[c] = 1'b1;
    daddr[c]   = addr;
    repeat (len) drive_slot();
    cctrans[c] = 0;
    done = cycles;
  endtask

  // coherence side seen by each core
  always @(negedge CLK) begin
    for (int c = 0; c < CPUS; c++) begin
      if (ccwait[c] && !snoop_seen[c]) begin
        snoop_seen[c] = 1'b1;
        snoop_addr[c] = ccsnoopaddr[c];
      end
      if (ccinv[c]) begin
        inv_seen[c] = 1'b1;
      end
    end
  end

  // no wait low without a request behind it
  no_spurious_iwait: assert property (@(negedge CLK) disable iff (!nRST)
    (~iwait & ~iren) == '0)
    else report_mismatch("iwait low for a core without iren");
  no_spurious_dwait: assert property (@(negedge CLK) disable iff (!nRST)
    (~dwait & ~(dren | dwen)) == '0)
    else report_mismatch("dwait low for a core without dren or dwen");
  // transition freezes every wait and hits the peer
  trans_holds_waits: assert property (@(negedge CLK) disable iff (!nRST)
    cctrans != '0 |-> (iwait == '1 && dwait == '1))
    else report_mismatch("wait low while cctrans is high");
  trans_hits_core1: assert property (@(negedge CLK) disable iff (!nRST)
    cctrans[0] |-> (ccwait[1] && ccinv[1] && ccsnoopaddr[1] == daddr[0]))
    else report_mismatch("core 1 not stalled and invalidated by cctrans[0]");
  trans_hits_core0: assert property (@(negedge CLK) disable iff (!nRST)
    (cctrans == 2'b10) |-> (ccwait[0] && ccinv[0] && ccsnoopaddr[0] == daddr[1]))
    else report_mismatch("core 0 not stalled and invalidated by cctrans[1]");

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("run timed out after %0d cycles with %0d errors", cycles, errors);
      $display("** FAIL **");
      $finish;
    end
  end

  initial begin
    int t0;
    int t1;
    int t2;
    iren       = '0;
    dren       = '0;
    dwen       = '0;
    iaddr      = '0;
    daddr      = '0;
    dstore     = '0;
    ccwrite    = '0;
    cctrans    = '0;
    lfsr_state = LFSR_SEED;
    snoop_seen = '0;
    snoop_addr = '0;
    inv_seen   = '0;
    @(posedge nRST);
    drive_slot();
    assert (iwait == '1 && dwait == '1 && ccwait == '0 && ccinv == '0)
      else report_mismatch("outputs not at reset values");

    // both cores at once, core 0 first and keeps the grant
    fork
      begin
        flush_word(0, 32'h40, t0);
        flush_word(0, 32'h44, t1);
      end
      flush_word(1, 32'h80, t2);
    join
    assert (t0 < t2 && t1 < t2)
      else report_mismatch($sformatf("core 1 done at %0d before core 0 at %0d", t2, t1));

    // flushed word visible to the other core's fetch
    fetch_word(1, 32'h40, t0);
    // clean read from RAM
    data_block(1, 32'h40, 1'b0, 1'b0);
    // peer modified, its data written back
    data_block(0, 32'h80, 1'b0, 1'b1);
    fetch_word(0, 32'h80, t0);
    fetch_word(1, 32'h84, t0);
    // write miss from the peer leaves RAM old
    data_block(1, 32'h40, 1'b1, 1'b1);
    fetch_word(1, 32'h40, t0);
    data_block(0, 32'h80, 1'b1, 1'b0);

    // pending fetch held until cctrans drops
    fork
      hold_trans(0, 32'h44, 6, t0);
      fetch_word(1, 32'h84, t1);
    join
    assert (t1 > t0)
      else report_mismatch("fetch finished while cctrans[0] was high");
    fork
      hold_trans(1, 32'h80, 5, t0);
      fetch_word(0, 32'h44, t1);
    join
    assert (t1 > t0)
      else report_mismatch("fetch finished while cctrans[1] was high");

    drive_slot();
    $display("checks done after %0d cycles, %0d errors", cycles, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: list.f
logic/cpu_types_pkg.sv
logic/coherence_pkg.sv
logic/ram_model.sv
logic/memory_control.sv
logic/memory_subsystem.sv
dv/tb_clock.sv
dv/memory_subsystem_tb.sv

// File: run.sh
#!/bin/sh
# build and run memory_subsystem_tb with Verilator, from the project root
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --assert -Wno-fatal \
  --top-module memory_subsystem_tb \
  -f list.f -o memory_subsystem_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/memory_subsystem_sim > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

# result is read from the log
if grep -q -F '** FAIL **' "$log"; then
  echo "simulation reported failure"
  exit 1
fi
exit 0
